/* all.f */
logic/axi_pkg.sv
logic/sram_pkg.sv
logic/sram_macro.sv
logic/sram_axi_slave.sv
logic/sram_subsystem.sv
tests/tb_sram_subsystem.sv

/* run.sh */
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" \
    && verilator --binary --assert -j 0 --top-module tb_sram_subsystem -f all.f \
    && ./obj_dir/Vtb_sram_subsystem | tee /dev/stderr | grep -q "^TB PASSED$" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* tests/tb_sram_subsystem.sv */
`timescale 1ns/1ps

module tb_sram_subsystem;

    localparam int TIMEOUT = 200;

    logic clk;
    logic rst;
    logic [axi_pkg::AXI_ID_BITS-1:0]    awid_i;
    logic [axi_pkg::AXI_ADDR_BITS-1:0]  awaddr_i;
    logic [axi_pkg::AXI_LEN_BITS-1:0]   awlen_i;
    logic [axi_pkg::AXI_SIZE_BITS-1:0]  awsize_i;
    logic [axi_pkg::AXI_BURST_BITS-1:0] awburst_i;
    logic                               awvalid_i;
    logic                               awready_o;
    logic [axi_pkg::AXI_DATA_BITS-1:0]  wdata_i;
    logic [axi_pkg::AXI_STRB_BITS-1:0]  wstrb_i;
    logic                               wlast_i;
    logic                               wvalid_i;
    logic                               wready_o;
    logic [axi_pkg::AXI_ID_BITS-1:0]    bid_o;
    logic [axi_pkg::AXI_RESP_BITS-1:0]  bresp_o;
    logic                               bvalid_o;
    logic                               bready_i;
    logic [axi_pkg::AXI_ID_BITS-1:0]    arid_i;
    logic [axi_pkg::AXI_ADDR_BITS-1:0]  araddr_i;
    logic [axi_pkg::AXI_LEN_BITS-1:0]   arlen_i;
    logic [axi_pkg::AXI_SIZE_BITS-1:0]  arsize_i;
    logic [axi_pkg::AXI_BURST_BITS-1:0] arburst_i;
    logic                               arvalid_i;
    logic                               arready_o;
    logic [axi_pkg::AXI_ID_BITS-1:0]    rid_o;
    logic [axi_pkg::AXI_DATA_BITS-1:0]  rdata_o;
    logic [axi_pkg::AXI_RESP_BITS-1:0]  rresp_o;
    logic                               rlast_o;
    logic                               rvalid_o;
    logic                               rready_i;

    // expected memory contents, indexed by word
    logic [31:0] shadow [sram_pkg::SRAM_DEPTH];
    logic [31:0] wr_data [16];
    logic [3:0]  wr_strb [16];
    logic [31:0] addr;
    integer      seed = 32'h8b7d;
    int          errors = 0;
    int          mark = 0;
    int          tests_ok = 0;
    int          tests_bad = 0;

    sram_subsystem uut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t: %s handshake never completed", $time, what);
        errors++;
        @(posedge clk);
    endtask

    task automatic close_test(input string name);
        if (errors == mark) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: failed with %0d errors", name, errors - mark);
        end
        mark = errors;
    endtask

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] strb);
        logic [31:0] res;
        res = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return res;
    endfunction

    task automatic fill_beats(input int beats, input logic [3:0] strb);
        for (int i = 0; i < beats; i++) begin
            wr_data[i] = $random(seed);
            wr_strb[i] = strb;
        end
    endtask

    task automatic check_response(input logic [7:0] id);
        compare_value("bvalid", 32'(bvalid_o), 1);
        compare_value("bid", 32'(bid_o), 32'(id));
        compare_value("bresp", 32'(bresp_o), 32'(axi_pkg::AXI_RESP_OKAY));
    endtask

    // entered on a rising edge, returns on a rising edge
    task automatic write_burst(input logic [31:0] base, input logic [7:0] id, input int beats,
                               input int bdelay);
        sram_pkg::sram_addr_u w;
        int t;
        w.raw = base;
        awid_i <= id;
        awaddr_i <= base;
        awlen_i <= 4'(beats - 1);
        awsize_i <= 3'd2;
        awburst_i <= axi_pkg::AXI_BURST_INCR;
        awvalid_i <= 1'b1;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (!awready_o && t < TIMEOUT);
        if (!awready_o) begin
            report_timeout("write address");
            return;
        end
        // write has priority over a pending read
        if (arvalid_i) begin
            compare_value("arready", 32'(arready_o), 0);
        end
        @(posedge clk);
        awvalid_i <= 1'b0;
        for (int beat = 0; beat < beats; beat++) begin
            while (($random(seed) & 3) == 0) begin
                wvalid_i <= 1'b0;
                @(posedge clk);
            end
            wdata_i <= wr_data[beat];
            wstrb_i <= wr_strb[beat];
            wlast_i <= (beat == beats - 1);
            wvalid_i <= 1'b1;
            t = 0;
            do begin
                @(negedge clk);
                t++;
            end while (!wready_o && t < TIMEOUT);
            if (!wready_o) begin
                report_timeout("write data");
                return;
            end
            @(posedge clk);
            shadow[w.fields.word] = merge_bytes(shadow[w.fields.word], wr_data[beat],
                                                wr_strb[beat]);
            w.fields.word = w.fields.word + 1'b1;
        end
        wvalid_i <= 1'b0;
        wlast_i <= 1'b0;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (!bvalid_o && t < TIMEOUT);
        if (!bvalid_o) begin
            report_timeout("write response");
            return;
        end
        // response must sit still while bready is held off
        repeat (bdelay) begin
            check_response(id);
            @(negedge clk);
        end
        @(posedge clk);
        bready_i <= 1'b1;
        @(negedge clk);
        check_response(id);
        if (arvalid_i) begin
            compare_value("arready", 32'(arready_o), 1);
        end
        @(posedge clk);
        bready_i <= 1'b0;
        arvalid_i <= 1'b0;
    endtask

    task automatic collect_read(input logic [31:0] base, input logic [7:0] id, input int beats,
                                input bit gaps);
        sram_pkg::sram_addr_u w;
        int t;
        int beat;
        w.raw = base;
        beat = 0;
        t = 0;
        rready_i <= !gaps;
        while (beat < beats && t < TIMEOUT) begin
            @(negedge clk);
            t++;
            if (rvalid_o) begin
                compare_value("rdata", rdata_o, shadow[w.fields.word]);
                compare_value("rlast", 32'(rlast_o), 32'(beat == beats - 1));
                compare_value("rid", 32'(rid_o), 32'(id));
                compare_value("rresp", 32'(rresp_o), 32'(axi_pkg::AXI_RESP_OKAY));
                if (rready_i) begin
                    beat++;
                    w.fields.word = w.fields.word + 1'b1;
                end
            end
            @(posedge clk);
            rready_i <= beat < beats && (!gaps || ($random(seed) & 1) != 0);
        end
        if (beat < beats) begin
            report_timeout("read data");
        end
    endtask

    task automatic read_burst(input logic [31:0] base, input logic [7:0] id, input int beats,
                              input bit gaps);
        int t;
        arid_i <= id;
        araddr_i <= base;
        arlen_i <= 4'(beats - 1);
        arsize_i <= 3'd2;
        arburst_i <= axi_pkg::AXI_BURST_INCR;
        arvalid_i <= 1'b1;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (!arready_o && t < TIMEOUT);
        if (!arready_o) begin
            report_timeout("read address");
            return;
        end
        @(posedge clk);
        arvalid_i <= 1'b0;
        collect_read(base, id, beats, gaps);
    endtask

    initial begin
        rst <= 1'b0;
        awid_i <= '0;
        awaddr_i <= '0;
        awlen_i <= '0;
        awsize_i <= '0;
        awburst_i <= '0;
        awvalid_i <= 1'b0;
        wdata_i <= '0;
        wstrb_i <= '0;
        wlast_i <= 1'b0;
        wvalid_i <= 1'b0;
        bready_i <= 1'b0;
        arid_i <= '0;
        araddr_i <= '0;
        arlen_i <= '0;
        arsize_i <= '0;
        arburst_i <= '0;
        arvalid_i <= 1'b0;
        rready_i <= 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b1;

        @(negedge clk);
        compare_value("rvalid", 32'(rvalid_o), 0);
        compare_value("bvalid", 32'(bvalid_o), 0);
        compare_value("wready", 32'(wready_o), 0);
        compare_value("awready", 32'(awready_o), 1);
        compare_value("arready", 32'(arready_o), 1);
        @(posedge clk);
        close_test("reset");

        addr = $random(seed) & 32'hffff_fffc;
        fill_beats(1, 4'hf);
        write_burst(addr, 8'h15, 1, 0);
        read_burst(addr, 8'h2a, 1, 0);
        close_test("single beat");

        addr = $random(seed) & 32'hffff_fffc;
        fill_beats(8, 4'hf);
        write_burst(addr, 8'h31, 8, 0);
        read_burst(addr, 8'h32, 8, 0);
        // start three words below the top so the burst wraps to word 0
        addr = (sram_pkg::SRAM_DEPTH - 3) * 4;
        fill_beats(8, 4'hf);
        write_burst(addr, 8'h33, 8, 0);
        read_burst(addr, 8'h34, 8, 0);
        close_test("burst of 8");

        addr = $random(seed) & 32'hffff_fffc;
        fill_beats(1, 4'hf);
        write_burst(addr, 8'h41, 1, 0);
        fill_beats(1, 4'b0101);
        write_burst(addr, 8'h42, 1, 0);
        read_burst(addr, 8'h43, 1, 0);
        fill_beats(1, 4'b1000);
        write_burst(addr, 8'h44, 1, 0);
        read_burst(addr, 8'h45, 1, 0);
        close_test("byte strobes");

        addr = $random(seed) & 32'hffff_fffc;
        fill_beats(8, 4'hf);
        write_burst(addr, 8'h51, 8, 3);
        read_burst(addr, 8'h52, 8, 1);
        close_test("back-pressure");

        // read raised with the write, aimed at an alias of the same words
        addr = $random(seed) & 32'hffff_fffc;
        fill_beats(2, 4'hf);
        arid_i <= 8'h6c;
        araddr_i <= addr ^ 32'h5a5a_0000;
        arlen_i <= 4'd1;
        arsize_i <= 3'd2;
        arburst_i <= axi_pkg::AXI_BURST_INCR;
        arvalid_i <= 1'b1;
        write_burst(addr, 8'h6b, 2, 1);
        collect_read(addr ^ 32'h5a5a_0000, 8'h6c, 2, 0);
        close_test("contention and aliasing");

        $display("tests passed %0d, tests failed %0d, errors %0d", tests_ok, tests_bad, errors);
        if (errors == 0 && tests_bad == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* logic/sram_subsystem.sv */
`timescale 1ns/1ps

module sram_subsystem (
    input  logic                                 clk,
    input  logic                                 rst,

    input  logic [axi_pkg::AXI_ID_BITS-1:0]      awid_i,
    input  logic [axi_pkg::AXI_ADDR_BITS-1:0]    awaddr_i,
    input  logic [axi_pkg::AXI_LEN_BITS-1:0]     awlen_i,
    input  logic [axi_pkg::AXI_SIZE_BITS-1:0]    awsize_i,
    input  logic [axi_pkg::AXI_BURST_BITS-1:0]   awburst_i,
    input  logic                                 awvalid_i,
    output logic                                 awready_o,

    input  logic [axi_pkg::AXI_DATA_BITS-1:0]    wdata_i,
    input  logic [axi_pkg::AXI_STRB_BITS-1:0]    wstrb_i,
    input  logic                                 wlast_i,
    input  logic                                 wvalid_i,
    output logic                                 wready_o,

    output logic [axi_pkg::AXI_ID_BITS-1:0]      bid_o,
    output logic [axi_pkg::AXI_RESP_BITS-1:0]    bresp_o,
    output logic                                 bvalid_o,
    input  logic                                 bready_i,

    input  logic [axi_pkg::AXI_ID_BITS-1:0]      arid_i,
    input  logic [axi_pkg::AXI_ADDR_BITS-1:0]    araddr_i,
    input  logic [axi_pkg::AXI_LEN_BITS-1:0]     arlen_i,
    input  logic [axi_pkg::AXI_SIZE_BITS-1:0]    arsize_i,
    input  logic [axi_pkg::AXI_BURST_BITS-1:0]   arburst_i,
    input  logic                                 arvalid_i,
    output logic                                 arready_o,

    output logic [axi_pkg::AXI_ID_BITS-1:0]      rid_o,
    output logic [axi_pkg::AXI_DATA_BITS-1:0]    rdata_o,
    output logic [axi_pkg::AXI_RESP_BITS-1:0]    rresp_o,
    output logic                                 rlast_o,
    output logic                                 rvalid_o,
    input  logic                                 rready_i
);

    // slave to macro pins
    logic [sram_pkg::SRAM_A_BITS-1:0]  sram_a;
    logic [sram_pkg::SRAM_D_BITS-1:0]  sram_di;
    logic [sram_pkg::SRAM_D_BITS-1:0]  sram_do;
    logic [sram_pkg::SRAM_WE_BITS-1:0] sram_web;
    logic                              sram_cs;
    logic                              sram_oe;

    sram_axi_slave u_slave (
        .clk        (clk),
        .rst        (rst),
        .awid_i     (awid_i),
        .awaddr_i   (awaddr_i),
        .awlen_i    (awlen_i),
        .awsize_i   (awsize_i),
        .awburst_i  (awburst_i),
        .awvalid_i  (awvalid_i),
        .awready_o  (awready_o),
        .wdata_i    (wdata_i),
        .wstrb_i    (wstrb_i),
        .wlast_i    (wlast_i),
        .wvalid_i   (wvalid_i),
        .wready_o   (wready_o),
        .bid_o      (bid_o),
        .bresp_o    (bresp_o),
        .bvalid_o   (bvalid_o),
        .bready_i   (bready_i),
        .arid_i     (arid_i),
        .araddr_i   (araddr_i),
        .arlen_i    (arlen_i),
        .arsize_i   (arsize_i),
        .arburst_i  (arburst_i),
        .arvalid_i  (arvalid_i),
        .arready_o  (arready_o),
        .rid_o      (rid_o),
        .rdata_o    (rdata_o),
        .rresp_o    (rresp_o),
        .rlast_o    (rlast_o),
        .rvalid_o   (rvalid_o),
        .rready_i   (rready_i),
        .sram_a_o   (sram_a),
        .sram_di_o  (sram_di),
        .sram_web_o (sram_web),
        .sram_cs_o  (sram_cs),
        .sram_oe_o  (sram_oe),
        .sram_do_i  (sram_do)
    );

    sram_macro u_sram (
        .clk   (clk),
        .a_i   (sram_a),
        .di_i  (sram_di),
        .web_i (sram_web),
        .cs_i  (sram_cs),
        .oe_i  (sram_oe),
        .do_o  (sram_do)
    );

endmodule

/* logic/sram_axi_slave.sv */
`timescale 1ns/1ps

module sram_axi_slave (
    input  logic                                 clk,
    input  logic                                 rst,

    // write address
    input  logic [axi_pkg::AXI_ID_BITS-1:0]      awid_i,
    input  logic [axi_pkg::AXI_ADDR_BITS-1:0]    awaddr_i,
    input  logic [axi_pkg::AXI_LEN_BITS-1:0]     awlen_i,
    input  logic [axi_pkg::AXI_SIZE_BITS-1:0]    awsize_i,
    input  logic [axi_pkg::AXI_BURST_BITS-1:0]   awburst_i,
    input  logic                                 awvalid_i,
    output logic                                 awready_o,

    // write data
    input  logic [axi_pkg::AXI_DATA_BITS-1:0]    wdata_i,
    input  logic [axi_pkg::AXI_STRB_BITS-1:0]    wstrb_i,
    input  logic                                 wlast_i,
    input  logic                                 wvalid_i,
    output logic                                 wready_o,

    // write response
    output logic [axi_pkg::AXI_ID_BITS-1:0]      bid_o,
    output logic [axi_pkg::AXI_RESP_BITS-1:0]    bresp_o,
    output logic                                 bvalid_o,
    input  logic                                 bready_i,

    // read address
    input  logic [axi_pkg::AXI_ID_BITS-1:0]      arid_i,
    input  logic [axi_pkg::AXI_ADDR_BITS-1:0]    araddr_i,
    input  logic [axi_pkg::AXI_LEN_BITS-1:0]     arlen_i,
    input  logic [axi_pkg::AXI_SIZE_BITS-1:0]    arsize_i,
    input  logic [axi_pkg::AXI_BURST_BITS-1:0]   arburst_i,
    input  logic                                 arvalid_i,
    output logic                                 arready_o,

    // read data
    output logic [axi_pkg::AXI_ID_BITS-1:0]      rid_o,
    output logic [axi_pkg::AXI_DATA_BITS-1:0]    rdata_o,
    output logic [axi_pkg::AXI_RESP_BITS-1:0]    rresp_o,
    output logic                                 rlast_o,
    output logic                                 rvalid_o,
    input  logic                                 rready_i,

    // sram pins
    output logic [sram_pkg::SRAM_A_BITS-1:0]      sram_a_o,
    output logic [sram_pkg::SRAM_D_BITS-1:0]      sram_di_o,
    output logic [sram_pkg::SRAM_WE_BITS-1:0]     sram_web_o,
    output logic                                 sram_cs_o,
    output logic                                 sram_oe_o,
    input  logic [sram_pkg::SRAM_D_BITS-1:0]      sram_do_i
);

    // size and burst type are taken but every burst runs as INCR by words

    logic [axi_pkg::AXI_SLV_STATE_BITS-1:0] state;
    logic [axi_pkg::AXI_SLV_STATE_BITS-1:0] next_state;

    logic awhns;
    logic arhns;
    logic whns;
    logic rhns;
    logic bhns;
    logic rdfin;
    logic wrfin;
    logic is_idle;
    logic xfer_end;
    logic accept;

    sram_pkg::sram_addr_u aw_addr;
    sram_pkg::sram_addr_u ar_addr;

    logic [axi_pkg::AXI_ID_BITS-1:0]  id_r;
    logic [axi_pkg::AXI_LEN_BITS-1:0] len_r;
    logic [axi_pkg::AXI_LEN_BITS-1:0] cnt;
    logic [sram_pkg::SRAM_A_BITS-1:0] addr_r;

    always_comb begin
        aw_addr.raw = awaddr_i;
        ar_addr.raw = araddr_i;
    end

    assign awhns = awvalid_i & awready_o;
    assign arhns = arvalid_i & arready_o;
    assign whns  = wvalid_i & wready_o;
    assign rhns  = rvalid_o & rready_i;
    assign bhns  = bvalid_o & bready_i;
    assign rdfin = rhns & rlast_o;
    assign wrfin = whns & wlast_i;

    // a new address may come in while idle or on the closing handshake
    assign is_idle  = (state == axi_pkg::AXI_SLV_IDLE);
    assign xfer_end = rdfin | bhns;
    assign accept   = is_idle | xfer_end;

    // write wins when both address channels are valid
    assign awready_o = accept;
    assign arready_o = accept & ~awvalid_i;
    assign wready_o  = (state == axi_pkg::AXI_SLV_WR);
    assign rvalid_o  = (state == axi_pkg::AXI_SLV_RD);
    assign bvalid_o  = (state == axi_pkg::AXI_SLV_RESP);

    assign rlast_o = rvalid_o & (cnt == len_r);
    assign rdata_o = sram_do_i;
    assign rid_o   = id_r;
    assign bid_o   = id_r;
    assign rresp_o = axi_pkg::AXI_RESP_OKAY;
    assign bresp_o = axi_pkg::AXI_RESP_OKAY;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= axi_pkg::AXI_SLV_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            axi_pkg::AXI_SLV_WR: begin
                if (wrfin) begin
                    next_state = axi_pkg::AXI_SLV_RESP;
                end
            end
            default: begin
                // idle, or read and response phases once they close
                if (awhns) begin
                    next_state = axi_pkg::AXI_SLV_WR;
                end else if (arhns) begin
                    next_state = axi_pkg::AXI_SLV_RD;
                end else if (accept) begin
                    next_state = axi_pkg::AXI_SLV_IDLE;
                end
            end
        endcase
    end

    // beat counter for rlast
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cnt <= '0;
        end else if (arhns) begin
            cnt <= '0;
        end else if (rhns) begin
            cnt <= cnt + 1'b1;
        end
    end

    // request fields and running word address
    always_ff @(posedge clk) begin
        if (awhns) begin
            id_r   <= awid_i;
            len_r  <= awlen_i;
            addr_r <= aw_addr.fields.word;
        end else if (arhns) begin
            id_r   <= arid_i;
            len_r  <= arlen_i;
            addr_r <= ar_addr.fields.word;
        end else if (whns | rhns) begin
            // wraps at the top of the macro
            addr_r <= addr_r + 1'b1;
        end
    end

    // read ahead on an accepted beat, else re-read the same word
    always_comb begin
        if (accept) begin
            sram_a_o = ar_addr.fields.word;
        end else if (rhns) begin
            sram_a_o = addr_r + 1'b1;
        end else begin
            sram_a_o = addr_r;
        end
    end

    always_comb begin
        case (state)
            axi_pkg::AXI_SLV_RD: begin
                sram_cs_o = rdfin ? arhns : 1'b1;
                sram_oe_o = rdfin ? arhns : 1'b1;
            end
            axi_pkg::AXI_SLV_WR: begin
                sram_cs_o = whns;
                sram_oe_o = 1'b0;
            end
            default: begin
                sram_cs_o = arhns;
                sram_oe_o = arhns;
            end
        endcase
    end

    // strobes become low enables only on a transferred beat
    assign sram_web_o = whns ? ~wstrb_i : '1;
    assign sram_di_o  = wdata_i;

endmodule

/* logic/sram_macro.sv */
`timescale 1ns/1ps

module sram_macro (
    input  logic                             clk,
    input  logic [sram_pkg::SRAM_A_BITS-1:0]  a_i,
    input  logic [sram_pkg::SRAM_D_BITS-1:0]  di_i,
    input  logic [sram_pkg::SRAM_WE_BITS-1:0] web_i,
    input  logic                             cs_i,
    input  logic                             oe_i,
    output logic [sram_pkg::SRAM_D_BITS-1:0]  do_o
);

    logic [sram_pkg::SRAM_D_BITS-1:0] mem [sram_pkg::SRAM_DEPTH];

    // byte writes, low enable selects the lane
    always_ff @(posedge clk) begin
        if (cs_i) begin
            for (int b = 0; b < sram_pkg::SRAM_WE_BITS; b++) begin
                if (!web_i[b]) begin
                    mem[a_i][b*8 +: 8] <= di_i[b*8 +: 8];
                end
            end
        end
    end

    // registered read port, do holds while oe is low
    always_ff @(posedge clk) begin
        if (cs_i && oe_i) begin
            do_o <= mem[a_i];
        end
    end

endmodule

/* logic/sram_pkg.sv */
package sram_pkg;

    // macro geometry
    localparam int SRAM_A_BITS  = 14;
    localparam int SRAM_DEPTH   = 1 << SRAM_A_BITS;
    localparam int SRAM_D_BITS  = 32;
    localparam int SRAM_WE_BITS = SRAM_D_BITS / 8;

    // byte offset inside a word, and what is left above the word index
    localparam int SRAM_OFF_BITS    = 2;
    localparam int SRAM_UNUSED_BITS = axi_pkg::AXI_ADDR_BITS - SRAM_A_BITS - SRAM_OFF_BITS;

    // bus address seen either whole or split for the macro
    // upper bits are dropped, so memory repeats across the space
    typedef union packed {
        logic [axi_pkg::AXI_ADDR_BITS-1:0] raw;
        struct packed {
            logic [SRAM_UNUSED_BITS-1:0] unused;
            logic [SRAM_A_BITS-1:0]      word;
            logic [SRAM_OFF_BITS-1:0]    byte_off;
        } fields;
    } sram_addr_u;

endpackage

/* logic/axi_pkg.sv */
package axi_pkg;

    // channel widths
    localparam int AXI_ADDR_BITS  = 32;
    localparam int AXI_DATA_BITS  = 32;
    localparam int AXI_STRB_BITS  = AXI_DATA_BITS / 8;
    localparam int AXI_ID_BITS    = 8;
    localparam int AXI_LEN_BITS   = 4;
    localparam int AXI_BURST_BITS = 2;
    localparam int AXI_SIZE_BITS  = 3;
    localparam int AXI_RESP_BITS  = 2;

    // response codes, only okay is ever returned
    localparam logic [AXI_RESP_BITS-1:0] AXI_RESP_OKAY = 2'b00;

    // burst encodings
    localparam logic [AXI_BURST_BITS-1:0] AXI_BURST_INCR = 2'b01;

    // slave transaction phases
    localparam int AXI_SLV_STATE_BITS = 2;
    localparam logic [AXI_SLV_STATE_BITS-1:0] AXI_SLV_IDLE = 2'h0;
    localparam logic [AXI_SLV_STATE_BITS-1:0] AXI_SLV_RD   = 2'h1;
    localparam logic [AXI_SLV_STATE_BITS-1:0] AXI_SLV_WR   = 2'h2;
    localparam logic [AXI_SLV_STATE_BITS-1:0] AXI_SLV_RESP = 2'h3;

endpackage
